// ==== rtl/wb_reg_pkg.sv ====
`default_nettype none

package wb_reg_pkg;

  typedef logic [31:0] wb_word_t;  // Bus data word and register contents.
  typedef logic [3:0]  wb_sel_t;   // One enable bit per byte lane.
  typedef logic [1:0]  reg_idx_t;  // Word index, address bits 3 down to 2.

  // Register map of the block.
  // Index 3 has no register behind it and is answered with err.
  localparam reg_idx_t REG_CTRL_A = 2'd0;  // Bus-written, read by user logic.
  localparam reg_idx_t REG_CTRL_B = 2'd1;  // Bus-written, read by user logic.
  localparam reg_idx_t REG_STATUS = 2'd2;  // Written by user logic, read-only on the bus.

endpackage

`default_nettype wire

// ==== rtl/wb_slave_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_slave_if
  import wb_reg_pkg::*;
(
  input wire wb_clk_i,
  input wire wb_rst_i
);

  logic     cyc;
  logic     stb;
  logic     we;
  reg_idx_t adr;
  wb_sel_t  sel;
  wb_word_t dat_w;
  wb_word_t dat_r;  // Zero unless ack is high.
  logic     ack;
  logic     err;

  // The decoder's end of one register port.
  modport master (
    output cyc, stb, we, adr, sel, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  wb_clk_i, wb_rst_i,
    input  cyc, stb, we, adr, sel, dat_w,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

// ==== rtl/wb_reg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_reg_decoder
  import wb_reg_pkg::*;
(
  input wire           wb_clk_i,
  input wire           wb_rst_i,
  input wire           cyc_i,
  input wire           stb_i,
  input wire           we_i,
  input wire reg_idx_t adr_i,
  input wire wb_sel_t  sel_i,
  input wire wb_word_t dat_i,
  output wb_word_t     dat_o,
  output logic         ack_o,
  output logic         err_o,
  wb_slave_if.master   ctrl_a,
  wb_slave_if.master   ctrl_b,
  wb_slave_if.master   status
);

  logic hit_a;
  logic hit_b;
  logic hit_s;
  logic mapped;
  logic err_q;  // One-cycle answer to an unmapped index.

  assign hit_a  = (adr_i == REG_CTRL_A);
  assign hit_b  = (adr_i == REG_CTRL_B);
  assign hit_s  = (adr_i == REG_STATUS);
  assign mapped = hit_a | hit_b | hit_s;

  // Only the addressed register sees a strobe or write data.
  assign ctrl_a.cyc   = cyc_i;
  assign ctrl_a.stb   = stb_i & hit_a;
  assign ctrl_a.we    = we_i & hit_a;
  assign ctrl_a.adr   = adr_i;
  assign ctrl_a.sel   = hit_a ? sel_i : '0;
  assign ctrl_a.dat_w = hit_a ? dat_i : '0;

  assign ctrl_b.cyc   = cyc_i;
  assign ctrl_b.stb   = stb_i & hit_b;
  assign ctrl_b.we    = we_i & hit_b;
  assign ctrl_b.adr   = adr_i;
  assign ctrl_b.sel   = hit_b ? sel_i : '0;
  assign ctrl_b.dat_w = hit_b ? dat_i : '0;

  assign status.cyc   = cyc_i;
  assign status.stb   = stb_i & hit_s;
  assign status.we    = we_i & hit_s;
  assign status.adr   = adr_i;
  assign status.sel   = hit_s ? sel_i : '0;
  assign status.dat_w = hit_s ? dat_i : '0;

  // A slave that is not acking drives zero, so a plain OR merges the replies.
  assign dat_o = ctrl_a.dat_r | ctrl_b.dat_r | status.dat_r;
  assign ack_o = ctrl_a.ack | ctrl_b.ack | status.ack;
  assign err_o = err_q | ctrl_a.err | ctrl_b.err | status.err;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= cyc_i & stb_i & ~mapped & ~err_q;  // Master drops stb after err.
    end
  end

  a_one_ack: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0({ctrl_a.ack, ctrl_b.ack, status.ack}));

endmodule

`default_nettype wire

// ==== rtl/wb_register_ppc2user.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_register_ppc2user
  import wb_reg_pkg::*;
#(
  parameter wb_word_t INIT_VAL = 32'h0000_0000
) (
  wb_slave_if.slave bus,
  input wire        user_clk,
  output wb_word_t  user_data_o
);

  wb_word_t reg_buffer;  // Bus-domain value, also what a read returns.
  logic     reg_ready;   // Bus side has a new value waiting.
  logic     reg_done;    // User side has taken the value.
  logic     done_r;
  logic     done_rr;
  logic     ready_r;
  logic     ready_rr;
  logic     ack_q;
  logic     req;
  logic     busy;

  assign req  = bus.cyc & bus.stb & ~ack_q;
  assign busy = reg_ready | done_rr;  // Handshake has not returned to idle yet.

  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.dat_r = ack_q ? reg_buffer : '0;

  // Bring done across into the bus clock.
  always_ff @(posedge bus.wb_clk_i) begin
    if (bus.wb_rst_i) begin
      done_r  <= 1'b0;
      done_rr <= 1'b0;
    end else begin
      done_r  <= reg_done;
      done_rr <= done_r;
    end
  end

  // A write is held off while a transfer is in flight.
  // Reads are answered at once.
  always_ff @(posedge bus.wb_clk_i) begin
    if (bus.wb_rst_i) begin
      ack_q      <= 1'b0;
      reg_ready  <= 1'b1;  // Sends INIT_VAL to the user side.
      reg_buffer <= INIT_VAL;
    end else begin
      ack_q <= 1'b0;
      if (req && !(bus.we && busy)) begin
        ack_q <= 1'b1;
        if (bus.we) begin
          reg_ready <= 1'b1;
          for (int i = 0; i < 4; i++) begin
            if (bus.sel[i]) begin
              reg_buffer[8*i +: 8] <= bus.dat_w[8*i +: 8];
            end
          end
        end
      end
      if (reg_ready && done_rr) begin
        reg_ready <= 1'b0;  // User side has the data.
      end
    end
  end

  // User clock domain.
  // The buffer cannot change before done has been seen low again.
  always_ff @(posedge user_clk) begin
    ready_r  <= reg_ready;
    ready_rr <= ready_r;
    reg_done <= ready_rr;  // Falls once ready has gone.
    if (ready_rr) begin
      user_data_o <= reg_buffer;
    end
  end

  // The user side reloads user_data_o for as long as it sees ready.
  a_buf_held: assert property (@(posedge user_clk) disable iff (bus.wb_rst_i)
    ready_rr |=> $stable(reg_buffer));

  a_out_on_done: assert property (@(posedge user_clk) disable iff (bus.wb_rst_i)
    $changed(user_data_o) |-> $rose(reg_done));

endmodule

`default_nettype wire

// ==== rtl/wb_register_user2ppc.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_register_user2ppc
  import wb_reg_pkg::*;
(
  wb_slave_if.slave    bus,
  input wire           user_clk,
  input wire wb_word_t user_data_i
);

  wb_word_t snap_buf;    // User-domain snapshot of user_data_i.
  logic     snap_ready;
  logic     snap_done;   // Driven from the bus clock.
  logic     done_r;
  logic     done_rr;
  logic     ready_r;
  logic     ready_rr;
  wb_word_t read_q;      // Bus-domain copy returned on reads.
  logic     ack_q;

  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.dat_r = ack_q ? read_q : '0;

  // User side restarts the handshake as soon as done has dropped.
  always_ff @(posedge user_clk) begin
    done_r     <= snap_done;
    done_rr    <= done_r;
    snap_ready <= ~done_rr;
    if (!snap_ready && !done_rr) begin
      snap_buf <= user_data_i;  // Start of a new round.
    end
  end

  always_ff @(posedge bus.wb_clk_i) begin
    if (bus.wb_rst_i) begin
      ready_r   <= 1'b0;
      ready_rr  <= 1'b0;
      snap_done <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      ready_r   <= snap_ready;
      ready_rr  <= ready_r;
      snap_done <= ready_rr;
      // Writes get an ack like reads do, and their data is dropped.
      ack_q <= bus.cyc & bus.stb & ~ack_q;
    end
  end

  // Take the snapshot once per round, on the first cycle ready is seen.
  always_ff @(posedge bus.wb_clk_i) begin
    if (ready_rr && !snap_done) begin
      read_q <= snap_buf;
    end
  end

  // The snapshot must hold still for as long as the bus side sees ready.
  a_buf_stable: assert property (@(posedge bus.wb_clk_i) disable iff (bus.wb_rst_i)
    ready_rr |-> $stable(snap_buf));

endmodule

`default_nettype wire

// ==== rtl/wb_sw_reg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_sw_reg_top
  import wb_reg_pkg::*;
#(
  parameter wb_word_t INIT_A = 32'h0000_00A5,
  parameter wb_word_t INIT_B = 32'h1234_5678
) (
  input wire           wb_clk_i,
  input wire           wb_rst_i,
  input wire           user_clk,
  input wire           wb_cyc_i,
  input wire           wb_stb_i,
  input wire           wb_we_i,
  input wire reg_idx_t wb_adr_i,
  input wire wb_sel_t  wb_sel_i,
  input wire wb_word_t wb_dat_i,
  output wb_word_t     wb_dat_o,
  output logic         wb_ack_o,
  output logic         wb_err_o,
  output wb_word_t     user_data_a_o,
  output wb_word_t     user_data_b_o,
  input wire wb_word_t user_status_i
);

  // One bus port per register, all in the bus clock domain.
  wb_slave_if ctrl_a_if (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i));
  wb_slave_if ctrl_b_if (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i));
  wb_slave_if status_if (.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i));

  wb_reg_decoder u_decoder (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .cyc_i    (wb_cyc_i),
    .stb_i    (wb_stb_i),
    .we_i     (wb_we_i),
    .adr_i    (wb_adr_i),
    .sel_i    (wb_sel_i),
    .dat_i    (wb_dat_i),
    .dat_o    (wb_dat_o),
    .ack_o    (wb_ack_o),
    .err_o    (wb_err_o),
    .ctrl_a   (ctrl_a_if),
    .ctrl_b   (ctrl_b_if),
    .status   (status_if)
  );

  wb_register_ppc2user #(.INIT_VAL(INIT_A)) u_ctrl_a (
    .bus         (ctrl_a_if),
    .user_clk    (user_clk),
    .user_data_o (user_data_a_o)
  );

  wb_register_ppc2user #(.INIT_VAL(INIT_B)) u_ctrl_b (
    .bus         (ctrl_b_if),
    .user_clk    (user_clk),
    .user_data_o (user_data_b_o)
  );

  wb_register_user2ppc u_status (
    .bus         (status_if),
    .user_clk    (user_clk),
    .user_data_i (user_status_i)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0,
  parameter real PHASE_NS  = 0.0
) (
  output logic clk_o
);

  // The first rising edge comes half a period after the phase offset.
  initial begin
    clk_o = 1'b0;
    #(PHASE_NS);
    forever begin
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_wb_sw_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_sw_reg
  import wb_reg_pkg::*;
();

  localparam wb_word_t INIT_A         = 32'h0000_00A5;
  localparam wb_word_t INIT_B         = 32'h1234_5678;
  localparam reg_idx_t REG_NONE       = 2'd3;  // No register behind this index.
  localparam int       TIMEOUT_CYCLES = 4000;  // About ten times the test length.
  localparam int       USER_WAIT      = 20;    // User clock cycles allowed for a crossing.

  logic     wb_clk_i;
  logic     user_clk;
  logic     wb_rst_i;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  reg_idx_t wb_adr_i;
  wb_sel_t  wb_sel_i;
  wb_word_t wb_dat_i;
  wb_word_t wb_dat_o;
  logic     wb_ack_o;
  logic     wb_err_o;
  wb_word_t user_data_a_o;
  wb_word_t user_data_b_o;
  wb_word_t user_status_i;

  int       seed = 32'h2804fc61;
  int       errors = 0;
  int       cycles = 0;
  wb_word_t shadow [0:3];  // Expected contents of each register, by index.
  logic     rd_chk = 1'b0;
  wb_word_t exp_dat;
  logic     usr_chk_a = 1'b0;
  logic     usr_chk_b = 1'b0;
  wb_word_t usr_exp;
  logic     seq_on = 1'b0;
  logic     seq_chk = 1'b0;
  wb_word_t seq_exp;
  wb_word_t prev_b;
  wb_word_t seq_q [$];  // Values written to CTRL_B that the user side has not shown yet.

  tb_clk_gen #(.PERIOD_NS(4.0), .PHASE_NS(0.0)) user_clk_gen (.clk_o(user_clk));
  tb_clk_gen #(.PERIOD_NS(4.0), .PHASE_NS(1.0)) wb_clk_gen (.clk_o(wb_clk_i));

  wb_sw_reg_top #(.INIT_A(INIT_A), .INIT_B(INIT_B)) dut_i (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .user_clk      (user_clk),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_sel_i      (wb_sel_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .wb_err_o      (wb_err_o),
    .user_data_a_o (user_data_a_o),
    .user_data_b_o (user_data_b_o),
    .user_status_i (user_status_i)
  );

  // Byte lanes with their sel bit set take the new byte, the others keep the old one.
  function automatic wb_word_t merge_lanes(wb_word_t old_val, wb_word_t new_val, wb_sel_t sel);
    wb_word_t res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic bus_access(input logic we, input reg_idx_t idx, input wb_sel_t sel,
                            input wb_word_t data, output logic acked);
    @(posedge wb_clk_i);
    #0.5;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = idx;
    wb_sel_i = sel;
    wb_dat_i = data;
    do begin
      @(posedge wb_clk_i);
      #0.5;
    end while (!wb_ack_o && !wb_err_o);
    acked    = wb_ack_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_sel_i = '0;
    wb_dat_i = '0;
    // The reply cycle is sampled by the checks at the next edge.
    @(posedge wb_clk_i);
    #0.5;
  endtask

  task automatic bus_write(input reg_idx_t idx, input wb_word_t data, input wb_sel_t sel);
    logic acked;
    bus_access(1'b1, idx, sel, data, acked);
    if (acked && (idx == REG_CTRL_A || idx == REG_CTRL_B)) begin
      shadow[idx] = merge_lanes(shadow[idx], data, sel);
    end
  endtask

  task automatic bus_read(input reg_idx_t idx, input wb_word_t exp);
    logic acked;
    exp_dat = exp;
    rd_chk  = (idx != REG_NONE);
    bus_access(1'b0, idx, '0, '0, acked);
    rd_chk  = 1'b0;
  endtask

  // Gives the user side up to USER_WAIT cycles, then lets the checks look once.
  task automatic wait_user(input reg_idx_t idx, input wb_word_t exp);
    wb_word_t cur;
    for (int n = 0; n < USER_WAIT; n++) begin
      @(posedge user_clk);
      #0.5;
      cur = (idx == REG_CTRL_A) ? user_data_a_o : user_data_b_o;
      if (cur == exp) begin
        break;
      end
    end
    usr_exp   = exp;
    usr_chk_a = (idx == REG_CTRL_A);
    usr_chk_b = (idx == REG_CTRL_B);
    @(posedge user_clk);
    #0.5;
    usr_chk_a = 1'b0;
    usr_chk_b = 1'b0;
  endtask

  // Every change of user_data_b_o during the sequence test must be the next queued value.
  always @(posedge user_clk) begin
    #0.5;
    seq_chk = 1'b0;
    if (seq_on && user_data_b_o != prev_b) begin
      if (seq_q.size() == 0) begin
        errors++;
        $display("user_data_b_o changed to %h with no write left to deliver", user_data_b_o);
      end else begin
        seq_exp = seq_q.pop_front();
        seq_chk = 1'b1;
      end
    end
    prev_b = user_data_b_o;
  end

  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d bus clock cycles, errors: %0d", cycles, errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  a_rd_data: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (rd_chk && wb_ack_o) |-> (wb_dat_o == exp_dat)) else begin
    errors++;
    $display("Mismatch wb_dat_o: got %h, expected %h", wb_dat_o, exp_dat);
  end

  a_rd_ack_time: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_cyc_i && wb_stb_i && !wb_we_i && wb_adr_i != REG_NONE && !wb_ack_o) |=> wb_ack_o)
  else begin
    errors++;
    $display("A read was not acked one cycle after its strobe");
  end

  a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o) else begin
    errors++;
    $display("wb_ack_o stayed high for two cycles");
  end

  a_dat_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !wb_ack_o |-> (wb_dat_o == '0)) else begin
    errors++;
    $display("Mismatch wb_dat_o: got %h, expected %h", wb_dat_o, 32'h0);
  end

  a_unmapped: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_cyc_i && wb_stb_i && wb_adr_i == REG_NONE && !wb_err_o) |=> (wb_err_o && !wb_ack_o))
  else begin
    errors++;
    $display("Access to index 3 was not answered with err alone");
  end

  a_user_a: assert property (@(posedge user_clk) usr_chk_a |-> (user_data_a_o == usr_exp))
  else begin
    errors++;
    $display("Mismatch user_data_a_o: got %h, expected %h", user_data_a_o, usr_exp);
  end

  a_user_b: assert property (@(posedge user_clk) usr_chk_b |-> (user_data_b_o == usr_exp))
  else begin
    errors++;
    $display("Mismatch user_data_b_o: got %h, expected %h", user_data_b_o, usr_exp);
  end

  a_seq_b: assert property (@(posedge user_clk) seq_chk |-> (user_data_b_o == seq_exp))
  else begin
    errors++;
    $display("Mismatch user_data_b_o: got %h, expected %h", user_data_b_o, seq_exp);
  end

  initial begin
    wb_word_t data;
    wb_sel_t  sel;
    reg_idx_t idx;
    wb_rst_i      = 1'b1;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_sel_i      = '0;
    wb_dat_i      = '0;
    user_status_i = '0;
    shadow[REG_CTRL_A] = INIT_A;
    shadow[REG_CTRL_B] = INIT_B;
    repeat (2) @(posedge wb_clk_i);
    #0.5;
    wb_rst_i = 1'b0;

    // Reset values reach both the bus and the user side.
    bus_read(REG_CTRL_A, INIT_A);
    bus_read(REG_CTRL_B, INIT_B);
    wait_user(REG_CTRL_A, INIT_A);
    wait_user(REG_CTRL_B, INIT_B);

    repeat (16) begin
      idx  = reg_idx_t'($random(seed) & 1);
      data = $random(seed);
      sel  = wb_sel_t'($random(seed));
      bus_write(idx, data, sel);
      bus_read(idx, shadow[idx]);
      wait_user(idx, shadow[idx]);
    end

    // Writes close together; most of them meet back-pressure.
    seq_on = 1'b1;
    for (int n = 0; n < 8; n++) begin
      data = $random(seed);
      if (data == shadow[REG_CTRL_B]) begin
        data = ~data;  // A repeated value would not show as a change.
      end
      seq_q.push_back(data);
      bus_write(REG_CTRL_B, data, 4'hF);
    end
    for (int n = 0; n < 4 * USER_WAIT && seq_q.size() != 0; n++) begin
      @(posedge user_clk);
    end
    repeat (2) @(posedge user_clk);
    a_seq_drained: assert (seq_q.size() == 0) else begin
      errors++;
      $display("%0d written values never reached user_data_b_o", seq_q.size());
    end
    seq_on = 1'b0;

    @(posedge wb_clk_i);
    #0.5;
    user_status_i = $random(seed);
    repeat (USER_WAIT) @(posedge user_clk);
    bus_read(REG_STATUS, user_status_i);

    bus_read(REG_NONE, '0);
    bus_write(REG_NONE, $random(seed), 4'hF);

    repeat (4) @(posedge wb_clk_i);
    $display("Run complete, errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/wb_reg_pkg.sv
rtl/wb_slave_if.sv
rtl/wb_reg_decoder.sv
rtl/wb_register_ppc2user.sv
rtl/wb_register_user2ppc.sv
rtl/wb_sw_reg_top.sv
testbench/tb_clk_gen.sv
testbench/tb_wb_sw_reg.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the run from its log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_wb_sw_reg -Mdir obj_dir -o sim_tb -f tb.f \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "Test run reported failure"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
exit 0
